// File: tb.f
+incdir+rtl
rtl/tcp_tx_pkg.sv
rtl/tx_arb_ctrl_pkg.sv
rtl/meta_rr_arbiter.sv
rtl/seq_queue.sv
rtl/tx_data_mux.sv
rtl/tx_arb_regs.sv
rtl/tcp_tx_arbiter.sv
dv/tb_tcp_tx_arbiter.sv

// File: Makefile
TOP = tb_tcp_tx_arbiter

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) \
		-Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log || ! grep -q '\*\* PASS \*\*' sim.log; then \
		echo "Simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_tcp_tx_arbiter.sv
// Directed testbench for the TX arbitration stage
// Region, engine and status models run in one clocked process, tests queue expectations
`timescale 1ns/1ps
`include "tx_arb_consts.svh"

module tb_tcp_tx_arbiter import tcp_tx_pkg::*, tx_arb_ctrl_pkg::*; ();

  localparam int CLK_PERIOD = 10;
  localparam int BEAT_W = `TX_DATA_BITS + `TX_KEEP_BITS + 1;
  // Beats per test 3 + 10 + 8 + 33 + 2
  localparam int TOTAL_BEATS = 56;
  localparam int WATCHDOG_NS = TOTAL_BEATS * 20 * CLK_PERIOD;

  logic                                   aclk;
  logic                                   aresetn;
  logic [`TX_N_REGIONS-1:0]               s_meta_valid;
  logic [`TX_N_REGIONS-1:0]               s_meta_ready;
  logic [`TX_N_REGIONS*`TX_META_BITS-1:0] s_meta_data;
  logic                                   m_meta_valid;
  logic                                   m_meta_ready;
  tcp_tx_meta_t                           m_meta_data;
  logic                                   s_stat_valid;
  logic                                   s_stat_ready;
  tcp_tx_stat_t                           s_stat_data;
  logic [`TX_N_REGIONS-1:0]               m_stat_valid;
  logic [`TX_N_REGIONS-1:0]               m_stat_ready;
  tcp_tx_stat_t                           m_stat_data;
  logic [`TX_N_REGIONS-1:0]               s_data_valid;
  logic [`TX_N_REGIONS-1:0]               s_data_ready;
  logic [`TX_N_REGIONS*`TX_DATA_BITS-1:0] s_data_tdata;
  logic [`TX_N_REGIONS*`TX_KEEP_BITS-1:0] s_data_tkeep;
  logic [`TX_N_REGIONS-1:0]               s_data_tlast;
  logic                                   m_data_valid;
  logic                                   m_data_ready;
  logic [`TX_DATA_BITS-1:0]               m_data_tdata;
  logic [`TX_KEEP_BITS-1:0]               m_data_tkeep;
  logic                                   m_data_tlast;
  logic                                   reg_wr;
  logic                                   reg_rd;
  logic [`TX_REG_ADDR_BITS-1:0]           reg_addr;
  logic [`TX_REG_BITS-1:0]                reg_wdata;
  logic [`TX_REG_BITS-1:0]                reg_rdata;

  // Region model storage, plain arrays with read and write indices
  tcp_tx_meta_t      rreq_mem  [`TX_N_REGIONS][16];
  logic [BEAT_W-1:0] rbeat_mem [`TX_N_REGIONS][128];
  int                rreq_wr [`TX_N_REGIONS];
  int                rreq_rd [`TX_N_REGIONS];
  int                rbeat_wr [`TX_N_REGIONS];
  int                rbeat_rd [`TX_N_REGIONS];
  logic [7:0]        load_tag [`TX_N_REGIONS];

  // Expected traffic, in grant order
  tcp_tx_meta_t      exp_req [$];
  logic [BEAT_W-1:0] exp_beat [$];
  tcp_tx_stat_t      exp_stat [$];
  int                exp_stat_region [$];
  logic [7:0]        exp_tag [`TX_N_REGIONS];
  int                exp_cnt [`TX_N_REGIONS];
  int                rr_model;

  // Engine statuses waiting to go back
  tcp_tx_stat_t      eng_q [$];
  logic              stall_en;
  logic [31:0]       lfsr;
  int                mism_cnt;
  int                other_cnt;

  tcp_tx_arbiter i_dut (.*);

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
  endfunction

  // Beat layout is {tlast, tkeep, tdata}, data names region, packet and beat
  function automatic logic [BEAT_W-1:0] beat_word(input int r, input logic [7:0] tag,
                                                  input int b, input int len);
    logic       last;
    logic [7:0] keep;
    last = (b == (len + 7) / 8 - 1);
    keep = (last && (len % 8 != 0)) ? (8'hFF >> (8 - len % 8)) : 8'hFF;
    return {last, keep, 16'(len), 8'(r), tag, 32'(b)};
  endfunction

  task automatic report_mismatch(input string msg);
    mism_cnt++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  task automatic report_error(input string msg);
    other_cnt++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // Region side, one request plus its payload beats
  task automatic region_load(input int r, input int len);
    tcp_tx_meta_t m;
    m.sid = {8'(r), load_tag[r]};
    m.len = 16'(len);
    rreq_mem[r][rreq_wr[r]] = m;
    rreq_wr[r]++;
    for (int b = 0; b < (len + 7) / 8; b++) begin
      rbeat_mem[r][rbeat_wr[r]] = beat_word(r, load_tag[r], b, len);
      rbeat_wr[r]++;
    end
    load_tag[r]++;
  endtask

  // Next grant in order, with its beats and status
  task automatic expect_packet(input int r, input int len);
    tcp_tx_meta_t m;
    tcp_tx_stat_t s;
    m.sid = {8'(r), exp_tag[r]};
    m.len = 16'(len);
    exp_req.push_back(m);
    for (int b = 0; b < (len + 7) / 8; b++) begin
      exp_beat.push_back(beat_word(r, exp_tag[r], b, len));
    end
    s.sid   = m.sid;
    s.len   = m.len;
    s.error = m.len[0];
    exp_stat.push_back(s);
    exp_stat_region.push_back(r);
    exp_tag[r]++;
    exp_cnt[r]++;
    rr_model = (r + 1) % `TX_N_REGIONS;
  endtask

  task automatic drain();
    do begin
      @(posedge aclk);
      #1;
    end while (exp_req.size() != 0 || exp_beat.size() != 0 || exp_stat.size() != 0
               || eng_q.size() != 0);
  endtask

  task automatic reg_write(input logic [`TX_REG_ADDR_BITS-1:0] addr, input logic [31:0] data);
    @(posedge aclk);
    #1;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge aclk);
    #1;
    reg_wr = 1'b0;
  endtask

  // Read data is registered, valid one cycle after the strobe
  task automatic reg_check(input logic [`TX_REG_ADDR_BITS-1:0] addr, input logic [31:0] exp,
                           input string what);
    logic [31:0] got;
    @(posedge aclk);
    #1;
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(posedge aclk);
    #1;
    reg_rd = 1'b0;
    got    = reg_rdata;
    if (got !== exp) begin
      report_mismatch($sformatf("%s read %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_counters();
    for (int r = 0; r < `TX_N_REGIONS; r++) begin
      reg_check({REG_PKT_CNT, 2'(r)}, 32'(exp_cnt[r]), $sformatf("packet counter %0d", r));
    end
  endtask

  // --------------------
  // Bus models and monitors
  // --------------------
  always @(posedge aclk) begin
    tcp_tx_meta_t      m;
    tcp_tx_stat_t      s;
    logic [BEAT_W-1:0] beat;
    int                r_exp;
    // Engine takes a request and queues its status
    if (m_meta_valid && m_meta_ready) begin
      if (exp_req.size() == 0) begin
        report_error($sformatf("request %h forwarded with none expected", m_meta_data));
      end else begin
        m = exp_req.pop_front();
        if (m_meta_data !== m) begin
          report_mismatch($sformatf("request %h, expected %h", m_meta_data, m));
        end
      end
      eng_q.push_back({m_meta_data.sid, m_meta_data.len, m_meta_data.len[0]});
    end
    if (m_data_valid && m_data_ready) begin
      if (exp_beat.size() == 0) begin
        report_error("output beat arrived with none expected");
      end else begin
        beat = exp_beat.pop_front();
        if ({m_data_tlast, m_data_tkeep, m_data_tdata} !== beat) begin
          report_mismatch($sformatf("beat %h, expected %h",
                                    {m_data_tlast, m_data_tkeep, m_data_tdata}, beat));
        end
      end
    end
    // Status back to its region
    for (int r = 0; r < `TX_N_REGIONS; r++) begin
      if (m_stat_valid[r] && m_stat_ready[r]) begin
        if (exp_stat.size() == 0) begin
          report_error($sformatf("status to region %0d with none expected", r));
        end else begin
          s     = exp_stat.pop_front();
          r_exp = exp_stat_region.pop_front();
          if (r != r_exp || m_stat_data !== s) begin
            report_mismatch($sformatf("status %h to region %0d, expected %h to %0d",
                                      m_stat_data, r, s, r_exp));
          end
        end
      end
      if (s_meta_valid[r] && s_meta_ready[r]) begin
        rreq_rd[r]++;
      end
      if (s_data_valid[r] && s_data_ready[r]) begin
        rbeat_rd[r]++;
      end
    end
    if ((s_stat_valid && s_stat_ready) != |(m_stat_valid & m_stat_ready)) begin
      report_mismatch("engine status handshake differs from region handshake");
    end
    if (s_stat_valid && s_stat_ready) begin
      void'(eng_q.pop_front());
    end
    #1;
    for (int r = 0; r < `TX_N_REGIONS; r++) begin
      s_meta_valid[r] = (rreq_rd[r] != rreq_wr[r]);
      s_meta_data[r*`TX_META_BITS +: `TX_META_BITS] =
        s_meta_valid[r] ? rreq_mem[r][rreq_rd[r]] : '0;
      s_data_valid[r] = (rbeat_rd[r] != rbeat_wr[r]);
      beat = s_data_valid[r] ? rbeat_mem[r][rbeat_rd[r]] : '0;
      s_data_tlast[r] = beat[BEAT_W-1];
      s_data_tkeep[r*`TX_KEEP_BITS +: `TX_KEEP_BITS] = beat[`TX_DATA_BITS +: `TX_KEEP_BITS];
      s_data_tdata[r*`TX_DATA_BITS +: `TX_DATA_BITS] = beat[`TX_DATA_BITS-1:0];
    end
    s_stat_valid = (eng_q.size() != 0);
    s_stat_data  = s_stat_valid ? eng_q[0] : '0;
    // One LFSR step per ready bit
    if (stall_en) begin
      lfsr         = lfsr_next(lfsr);
      m_data_ready = lfsr[0];
      lfsr         = lfsr_next(lfsr);
      m_meta_ready = lfsr[0];
    end else begin
      m_data_ready = 1'b1;
      m_meta_ready = 1'b1;
    end
  end

  // --------------------
  // Tests
  // --------------------
  task automatic check_reset_state();
    @(posedge aclk);
    #1;
    if ({m_meta_valid, m_data_valid, s_stat_ready, |m_stat_valid, |s_meta_ready,
         |s_data_ready} !== 6'b0) begin
      report_mismatch("valid or ready output high after reset");
    end
    reg_check({REG_EN_MASK, 2'd0}, 32'hF, "enable mask");
    check_counters();
  endtask

  task automatic single_packet();
    region_load(2, 20);
    expect_packet(2, 20);
    drain();
    check_counters();
  endtask

  task automatic round_robin();
    int lens [`TX_N_REGIONS] = '{8, 17, 40, 1};
    for (int r = 0; r < `TX_N_REGIONS; r++) begin
      region_load(r, lens[r]);
    end
    // Rotation starts at the pointer
    for (int i = 0; i < `TX_N_REGIONS; i++) begin
      expect_packet(rr_model, lens[rr_model]);
    end
    drain();
  endtask

  task automatic mask_blocking();
    int start;
    int r;
    reg_write({REG_EN_MASK, 2'd0}, 32'hD);
    start = rr_model;
    for (int i = 0; i < `TX_N_REGIONS; i++) begin
      region_load(i, 16);
      r = (start + i) % `TX_N_REGIONS;
      if (r != 1) begin
        expect_packet(r, 16);
      end
    end
    drain();
    repeat (4) @(posedge aclk);
    #1;
    if (m_meta_valid) begin
      report_error("masked region 1 was granted");
    end
    expect_packet(1, 16);
    reg_write({REG_EN_MASK, 2'd0}, 32'hF);
    drain();
  endtask

  task automatic back_pressure();
    int start;
    int r;
    stall_en = 1'b1;
    start    = rr_model;
    for (int p = 0; p < 3; p++) begin
      for (int i = 0; i < `TX_N_REGIONS; i++) begin
        region_load(i, 8 * (p + 1) + i);
      end
    end
    for (int p = 0; p < 3; p++) begin
      for (int i = 0; i < `TX_N_REGIONS; i++) begin
        r = (start + i) % `TX_N_REGIONS;
        expect_packet(r, 8 * (p + 1) + r);
      end
    end
    drain();
    stall_en = 1'b0;
  endtask

  task automatic status_routing();
    int start;
    int r;
    int hold;
    start = rr_model;
    hold  = -1;
    region_load(0, 8);
    region_load(3, 8);
    for (int i = 0; i < `TX_N_REGIONS; i++) begin
      r = (start + i) % `TX_N_REGIONS;
      if (r == 0 || r == 3) begin
        expect_packet(r, 8);
        if (hold < 0) begin
          hold = r;
        end
      end
    end
    // First granted region refuses its status for a while
    m_stat_ready = ~(`TX_N_REGIONS'(1) << hold);
    while (!s_stat_valid) begin
      @(posedge aclk);
      #1;
    end
    repeat (3) @(posedge aclk);
    #1;
    if (s_stat_ready !== 1'b0 || m_stat_valid !== (`TX_N_REGIONS'(1) << hold)) begin
      report_mismatch($sformatf("stalled status: ready %b valid %b", s_stat_ready,
                                m_stat_valid));
    end
    m_stat_ready = '1;
    drain();
    check_counters();
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    aresetn      = 1'b0;
    s_meta_valid = '0;
    s_meta_data  = '0;
    m_meta_ready = 1'b0;
    s_stat_valid = 1'b0;
    s_stat_data  = '0;
    m_stat_ready = '1;
    s_data_valid = '0;
    s_data_tdata = '0;
    s_data_tkeep = '0;
    s_data_tlast = '0;
    m_data_ready = 1'b0;
    reg_wr       = 1'b0;
    reg_rd       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    stall_en     = 1'b0;
    lfsr         = 32'h081f94d6;
    rr_model     = 0;
    mism_cnt     = 0;
    other_cnt    = 0;
    for (int r = 0; r < `TX_N_REGIONS; r++) begin
      rreq_wr[r]  = 0;
      rreq_rd[r]  = 0;
      rbeat_wr[r] = 0;
      rbeat_rd[r] = 0;
      load_tag[r] = '0;
      exp_tag[r]  = '0;
      exp_cnt[r]  = 0;
    end
    repeat (2) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    check_reset_state();
    single_packet();
    round_robin();
    mask_blocking();
    back_pressure();
    status_routing();
    $display("Run complete: %0d mismatches, %0d other errors", mism_cnt, other_cnt);
    if (mism_cnt == 0 && other_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t, tests did not complete", $time);
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: rtl/tcp_tx_arbiter.sv
// Top of the TX arbitration stage for the multi-region TCP offload shell
// Requests, payload and statuses of all regions share one engine port
`timescale 1ns/1ps
`include "tx_arb_consts.svh"

module tcp_tx_arbiter import tcp_tx_pkg::*; (
  input  logic                                    aclk,
  input  logic                                    aresetn,
  // Region requests
  input  logic [`TX_N_REGIONS-1:0]                s_meta_valid,
  output logic [`TX_N_REGIONS-1:0]                s_meta_ready,
  input  logic [`TX_N_REGIONS*`TX_META_BITS-1:0]  s_meta_data,
  // Engine request
  output logic                                    m_meta_valid,
  input  logic                                    m_meta_ready,
  output tcp_tx_meta_t                            m_meta_data,
  // Status from engine, back to regions
  input  logic                                    s_stat_valid,
  output logic                                    s_stat_ready,
  input  tcp_tx_stat_t                            s_stat_data,
  output logic [`TX_N_REGIONS-1:0]                m_stat_valid,
  input  logic [`TX_N_REGIONS-1:0]                m_stat_ready,
  output tcp_tx_stat_t                            m_stat_data,
  // Region payload
  input  logic [`TX_N_REGIONS-1:0]                s_data_valid,
  output logic [`TX_N_REGIONS-1:0]                s_data_ready,
  input  logic [`TX_N_REGIONS*`TX_DATA_BITS-1:0]  s_data_tdata,
  input  logic [`TX_N_REGIONS*`TX_KEEP_BITS-1:0]  s_data_tkeep,
  input  logic [`TX_N_REGIONS-1:0]                s_data_tlast,
  // Engine payload
  output logic                                    m_data_valid,
  input  logic                                    m_data_ready,
  output logic [`TX_DATA_BITS-1:0]                m_data_tdata,
  output logic [`TX_KEEP_BITS-1:0]                m_data_tkeep,
  output logic                                    m_data_tlast,
  // Registers
  input  logic                                    reg_wr,
  input  logic                                    reg_rd,
  input  logic [`TX_REG_ADDR_BITS-1:0]            reg_addr,
  input  logic [`TX_REG_BITS-1:0]                 reg_wdata,
  output logic [`TX_REG_BITS-1:0]                 reg_rdata
);

  logic [`TX_REGION_BITS-1:0]             grant_id;
  logic                                   out_ready;
  logic [`TX_N_REGIONS-1:0]               en_mask;
  logic                                   lq_full, lq_empty, lq_pop;
  logic [`TX_REGION_BITS+`TX_LEN_BITS-1:0] lq_head;
  logic                                   rq_full, rq_empty, rq_pop;
  logic [`TX_REGION_BITS-1:0]             rq_head;
  logic                                   done;
  logic [`TX_REGION_BITS-1:0]             done_id;

  // --------------------
  // Request path
  // --------------------
  // Stall everyone unless engine and both queues can take it
  assign out_ready = m_meta_ready & ~lq_full & ~rq_full;

  meta_rr_arbiter i_arb (
    .aclk, .aresetn,
    .s_meta_valid, .s_meta_ready, .s_meta_data,
    .en_mask, .out_ready,
    .m_meta_valid, .m_meta_data, .grant_id
  );

  // Region and length, consumed by the data mux
  seq_queue #(.WIDTH(`TX_REGION_BITS + `TX_LEN_BITS), .DEPTH(`TX_QDEPTH)) i_len_q (
    .aclk, .aresetn,
    .push(m_meta_valid), .push_data({grant_id, m_meta_data.len}), .full(lq_full),
    .pop(lq_pop), .head(lq_head), .empty(lq_empty)
  );

  // Region only, consumed by status routing
  seq_queue #(.WIDTH(`TX_REGION_BITS), .DEPTH(`TX_QDEPTH)) i_reg_q (
    .aclk, .aresetn,
    .push(m_meta_valid), .push_data(grant_id), .full(rq_full),
    .pop(rq_pop), .head(rq_head), .empty(rq_empty)
  );

  // --------------------
  // Data path
  // --------------------
  tx_data_mux i_mux (
    .aclk, .aresetn,
    .q_head(lq_head), .q_empty(lq_empty), .q_pop(lq_pop),
    .s_data_valid, .s_data_ready, .s_data_tdata, .s_data_tkeep, .s_data_tlast,
    .m_data_valid, .m_data_ready, .m_data_tdata, .m_data_tkeep, .m_data_tlast,
    .done, .done_id
  );

  tx_arb_regs i_regs (
    .aclk, .aresetn,
    .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata,
    .done, .done_id, .en_mask
  );

  // --------------------
  // Status routing
  // --------------------
  // Oldest outstanding request owns the next status
  for (genvar i = 0; i < `TX_N_REGIONS; i++) begin : g_stat
    assign m_stat_valid[i] = s_stat_valid && !rq_empty
                             && (rq_head == `TX_REGION_BITS'(i));
  end
  assign m_stat_data  = s_stat_data;
  assign s_stat_ready = !rq_empty && m_stat_ready[rq_head];
  assign rq_pop       = s_stat_valid & s_stat_ready;

endmodule

// File: rtl/tx_arb_regs.sv
// Control registers beside the arbiter
// Region enable mask plus read-only completed-packet counters
`timescale 1ns/1ps
`include "tx_arb_consts.svh"

module tx_arb_regs import tx_arb_ctrl_pkg::*; (
  input  logic                         aclk,
  input  logic                         aresetn,
  input  logic                         reg_wr,
  input  logic                         reg_rd,
  input  logic [`TX_REG_ADDR_BITS-1:0] reg_addr,
  input  logic [`TX_REG_BITS-1:0]      reg_wdata,
  output logic [`TX_REG_BITS-1:0]      reg_rdata,
  input  logic                         done,
  input  logic [`TX_REGION_BITS-1:0]   done_id,
  output logic [`TX_N_REGIONS-1:0]     en_mask
);

  tx_reg_op_t                 op;
  logic [`TX_REGION_BITS-1:0] idx;
  logic [`TX_CNT_BITS-1:0]    pkt_cnt [`TX_N_REGIONS];

  // Opcode on top, region index below
  assign op  = tx_reg_op_t'(reg_addr[`TX_REG_ADDR_BITS-1 -: `TX_REG_OP_BITS]);
  assign idx = reg_addr[`TX_REGION_BITS-1:0];

  // Mask, all regions on after reset
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      en_mask <= '1;
    end else if (reg_wr && op == REG_EN_MASK) begin
      en_mask <= reg_wdata[`TX_N_REGIONS-1:0];
    end
  end

  // Packet counters, wrap at 16 bits
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      for (int i = 0; i < `TX_N_REGIONS; i++) begin
        pkt_cnt[i] <= '0;
      end
    end else if (done) begin
      pkt_cnt[done_id] <= pkt_cnt[done_id] + 1'b1;
    end
  end

  // Registered read, unknown opcodes read zero
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      reg_rdata <= '0;
    end else if (reg_rd) begin
      case (op)
        REG_EN_MASK: reg_rdata <= `TX_REG_BITS'(en_mask);
        REG_PKT_CNT: reg_rdata <= `TX_REG_BITS'(pkt_cnt[idx]);
        default:     reg_rdata <= '0;
      endcase
    end
  end

endmodule

// File: rtl/tx_data_mux.sv
// Forwards the payload beats of each granted request, in grant order
// Pops the length queue and switches one region stream through to the output
`timescale 1ns/1ps
`include "tx_arb_consts.svh"

module tx_data_mux import tx_arb_ctrl_pkg::*; (
  input  logic                                    aclk,
  input  logic                                    aresetn,
  input  logic [`TX_REGION_BITS+`TX_LEN_BITS-1:0] q_head,
  input  logic                                    q_empty,
  output logic                                    q_pop,
  input  logic [`TX_N_REGIONS-1:0]                s_data_valid,
  output logic [`TX_N_REGIONS-1:0]                s_data_ready,
  input  logic [`TX_N_REGIONS*`TX_DATA_BITS-1:0]  s_data_tdata,
  input  logic [`TX_N_REGIONS*`TX_KEEP_BITS-1:0]  s_data_tkeep,
  input  logic [`TX_N_REGIONS-1:0]                s_data_tlast,
  output logic                                    m_data_valid,
  input  logic                                    m_data_ready,
  output logic [`TX_DATA_BITS-1:0]                m_data_tdata,
  output logic [`TX_KEEP_BITS-1:0]                m_data_tkeep,
  output logic                                    m_data_tlast,
  output logic                                    done,
  output logic [`TX_REGION_BITS-1:0]              done_id
);

  mux_state_t                   state;
  logic [`TX_REGION_BITS-1:0]   region_sel;
  logic [`TX_BEAT_CNT_BITS-1:0] last_beat;
  logic [`TX_BEAT_CNT_BITS-1:0] beat_cnt;

  logic [`TX_REGION_BITS-1:0]   head_region;
  logic [`TX_LEN_BITS-1:0]      head_len;
  logic [`TX_BEAT_CNT_BITS-1:0] head_words;
  logic [`TX_BEAT_CNT_BITS-1:0] head_last;
  logic                         beat_xfer;
  logic                         final_beat;

  // --------------------
  // Beat count
  // --------------------
  assign head_len    = q_head[`TX_LEN_BITS-1:0];
  assign head_region = q_head[`TX_LEN_BITS +: `TX_REGION_BITS];
  assign head_words  = head_len[`TX_LEN_BITS-1:`TX_BEAT_LOG];

  // Index of last beat, ceil(len/8) - 1
  // zero length still sends one beat
  assign head_last = (head_words == '0) ? '0 :
                     (|head_len[`TX_BEAT_LOG-1:0]) ? head_words : head_words - 1'b1;

  assign beat_xfer  = m_data_valid & m_data_ready;
  assign final_beat = (state == MUX_SEND) & beat_xfer & (beat_cnt == last_beat);

  // Load from idle, or back to back after the last beat
  assign q_pop = !q_empty && ((state == MUX_IDLE) || final_beat);

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state    <= MUX_IDLE;
      beat_cnt <= '0;
    end else begin
      if (q_pop) begin
        state    <= MUX_SEND;
        beat_cnt <= '0;
      end else if (final_beat) begin
        state <= MUX_IDLE;
      end else if (beat_xfer) begin
        // Stalls hold the count
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // Latched packet
  always_ff @(posedge aclk) begin
    if (q_pop) begin
      region_sel <= head_region;
      last_beat  <= head_last;
    end
  end

  // --------------------
  // Stream switch
  // --------------------
  assign m_data_valid = (state == MUX_SEND) & s_data_valid[region_sel];
  assign m_data_tdata = s_data_tdata[region_sel*`TX_DATA_BITS +: `TX_DATA_BITS];
  assign m_data_tkeep = s_data_tkeep[region_sel*`TX_KEEP_BITS +: `TX_KEEP_BITS];
  assign m_data_tlast = s_data_tlast[region_sel];

  // Only the selected region sees ready
  for (genvar i = 0; i < `TX_N_REGIONS; i++) begin : g_ready
    assign s_data_ready[i] = (state == MUX_SEND) && (region_sel == `TX_REGION_BITS'(i))
                             && m_data_ready;
  end

  assign done    = final_beat;
  assign done_id = region_sel;

  a_idle_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
    (state == MUX_IDLE) |-> !m_data_valid);

endmodule

// File: rtl/seq_queue.sv
// Small FIFO for the order of in-flight requests
// Head is read combinationally, a push shows at the head one cycle later
`timescale 1ns/1ps

module seq_queue #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 4
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  output logic             full,
  input  logic             pop,
  output logic [WIDTH-1:0] head,
  output logic             empty
);

  localparam int unsigned PTR_BITS = $clog2(DEPTH);
  localparam int unsigned CNT_BITS = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]    mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;

  assign full  = (count == CNT_BITS'(DEPTH));
  assign empty = (count == '0);
  assign head  = mem[rd_ptr];

  // Storage
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at DEPTH
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy holds on push with pop
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn) push |-> !full);
  a_no_underflow: assert property (@(posedge aclk) disable iff (!aresetn) pop |-> !empty);

endmodule

// File: rtl/meta_rr_arbiter.sv
// Round-robin grant over the per-region send requests
// Grant is combinational and only fires when out_ready is high
`timescale 1ns/1ps
`include "tx_arb_consts.svh"

module meta_rr_arbiter import tcp_tx_pkg::*; (
  input  logic                                      aclk,
  input  logic                                      aresetn,
  input  logic [`TX_N_REGIONS-1:0]                  s_meta_valid,
  output logic [`TX_N_REGIONS-1:0]                  s_meta_ready,
  input  logic [`TX_N_REGIONS*`TX_META_BITS-1:0]    s_meta_data,
  input  logic [`TX_N_REGIONS-1:0]                  en_mask,
  input  logic                                      out_ready,
  output logic                                      m_meta_valid,
  output tcp_tx_meta_t                              m_meta_data,
  output logic [`TX_REGION_BITS-1:0]                grant_id
);

  logic [`TX_REGION_BITS-1:0] rr_ptr;
  logic [`TX_REGION_BITS-1:0] sel;
  logic [`TX_REGION_BITS-1:0] idx;
  logic [`TX_N_REGIONS-1:0]   req;
  logic                       any_req;
  logic                       grant;

  // Search from the pointer, first hit wins
  always_comb begin
    req     = s_meta_valid & en_mask;
    any_req = 1'b0;
    sel     = rr_ptr;
    idx     = rr_ptr;
    for (int i = 0; i < `TX_N_REGIONS; i++) begin
      // Index wraps in the region width
      idx = rr_ptr + i[`TX_REGION_BITS-1:0];
      if (!any_req && req[idx]) begin
        any_req = 1'b1;
        sel     = idx;
      end
    end
  end

  // Engine and both queues must take it this cycle
  assign grant        = any_req & out_ready;
  assign s_meta_ready = grant ? (`TX_N_REGIONS'(1) << sel) : '0;
  assign m_meta_valid = grant;
  assign m_meta_data  = s_meta_data[sel*`TX_META_BITS +: `TX_META_BITS];
  assign grant_id     = sel;

  // Next search starts after the winner
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr_ptr <= '0;
    end else if (grant) begin
      rr_ptr <= sel + 1'b1;
    end
  end

  // --------------------
  // Checks
  // --------------------
  a_ready_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(s_meta_ready));
  a_grant_enabled: assert property (@(posedge aclk) disable iff (!aresetn)
    (|s_meta_ready) |-> ((s_meta_ready & ~en_mask) == '0));

endmodule

// File: rtl/tx_arb_ctrl_pkg.sv
// Control enums for the data multiplexer FSM and the register port
`include "tx_arb_consts.svh"

package tx_arb_ctrl_pkg;

  // Data mux FSM
  typedef enum logic {
    MUX_IDLE = 1'b0,
    MUX_SEND = 1'b1
  } mux_state_t;

  // Upper address bits of the register port
  typedef enum logic [`TX_REG_OP_BITS-1:0] {
    REG_EN_MASK = 2'd0,
    REG_PKT_CNT = 2'd1
  } tx_reg_op_t;

endpackage

// File: rtl/tcp_tx_pkg.sv
// Request and status records seen by the regions and the TCP engine
// Import wherever the meta or status ports are typed
`include "tx_arb_consts.svh"

package tcp_tx_pkg;

  // Send request from a region
  typedef struct packed {
    logic [`TX_SID_BITS-1:0] sid;
    logic [`TX_LEN_BITS-1:0] len;
  } tcp_tx_meta_t;

  // Engine status, opaque to the arbiter
  typedef struct packed {
    logic [`TX_SID_BITS-1:0] sid;
    logic [`TX_LEN_BITS-1:0] len;
    logic                    error;
  } tcp_tx_stat_t;

endpackage

// File: rtl/tx_arb_consts.svh
// Shared sizes for the TX arbitration stage
// Include wherever region, length or beat widths are needed
`ifndef TX_ARB_CONSTS_SVH
`define TX_ARB_CONSTS_SVH

// Regions
`define TX_N_REGIONS 4
`define TX_REGION_BITS 2

// Request fields
`define TX_SID_BITS 16
`define TX_LEN_BITS 16
`define TX_META_BITS (`TX_SID_BITS + `TX_LEN_BITS)

// Stream beat, 8 bytes
`define TX_DATA_BITS 64
`define TX_KEEP_BITS (`TX_DATA_BITS / 8)
`define TX_BEAT_LOG 3
`define TX_BEAT_CNT_BITS (`TX_LEN_BITS - `TX_BEAT_LOG)

// Outstanding requests
`define TX_QDEPTH 4

// Register port
`define TX_REG_OP_BITS 2
`define TX_REG_ADDR_BITS (`TX_REG_OP_BITS + `TX_REGION_BITS)
`define TX_REG_BITS 32
`define TX_CNT_BITS 16

`endif
